//--- source/tcdm_pkg.sv
/*
  TCDM word interface types. Addresses are byte addresses and
  data is one 32-bit word. wen is active low, 0 means write.
*/
`default_nettype none

package tcdm_pkg;

  localparam int unsigned TCDM_ADDR_W = 32;           // Byte address width
  localparam int unsigned TCDM_DATA_W = 32;           // Word width
  localparam int unsigned TCDM_BE_W   = TCDM_DATA_W / 8; // One enable per byte

  typedef logic [TCDM_ADDR_W-1:0] tcdm_addr_t;
  typedef logic [TCDM_DATA_W-1:0] tcdm_data_t;
  typedef logic [TCDM_BE_W-1:0]   tcdm_be_t;

  // Outgoing queue payload, 69 bits
  typedef struct packed {
    tcdm_addr_t addr;
    tcdm_data_t data;
    tcdm_be_t   be;
    logic       wen;                                  // Low for write
  } tcdm_req_t;

endpackage

`default_nettype wire

//--- source/fifo_pkg.sv
/*
  FIFO status flags shared by all queues of the design.
*/
`default_nettype none

package fifo_pkg;

  // Status as seen after the last clock edge
  typedef struct packed {
    logic empty;                                      // No entry stored
    logic full;                                       // No free slot
  } fifo_flags_t;

endpackage

`default_nettype wire

//--- source/stream_fifo.sv
/*
  Single-clock valid/ready queue on a register array.
  FIFO_DEPTH must be a power of two, at least 2.
  push_ready_o is the registered not-full and never looks at the pop side.
*/
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter int unsigned FIFO_DEPTH = 8,
  parameter type         payload_t  = logic [31:0]
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  push_valid_i,
  input  payload_t              push_data_i,
  output logic                  push_ready_o,
  output logic                  pop_valid_o,
  output payload_t              pop_data_o,
  input  logic                  pop_ready_i,
  output fifo_pkg::fifo_flags_t flags_o
);

  import fifo_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  payload_t         mem_q [FIFO_DEPTH];             // Entry storage
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;                        // Entries held
  logic             push_en;
  logic             pop_en;
  fifo_flags_t      flags;

  // ####################
  // Status and handshakes
  assign flags.empty  = (count_q == '0);
  assign flags.full   = (count_q == CNT_W'(FIFO_DEPTH));
  assign flags_o      = flags;

  assign push_ready_o = ~flags.full;
  assign pop_valid_o  = ~flags.empty;
  assign pop_data_o   = mem_q[rd_ptr_q];            // Head of queue

  assign push_en      = push_valid_i & push_ready_o;
  assign pop_en       = pop_valid_o & pop_ready_i;

  // ####################
  // Pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;                               // Drop all entries
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) wr_ptr_q <= wr_ptr_q + 1'b1;     // Wraps at depth
      if (pop_en)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;                // Both or none
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_en) mem_q[wr_ptr_q] <= push_data_i;
  end

  // ####################
  // Checks
  a_push_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (push_valid_i && !push_ready_o) |=> (!push_valid_i || $stable(push_data_i)))
    else $error("push data changed while waiting for ready");

  // Occupancy tracks the pointer distance
  a_count_ptrs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    PTR_W'(count_q) == PTR_W'(wr_ptr_q - rd_ptr_q))
    else $error("queue occupancy does not match pointer distance");

endmodule

`default_nettype wire

//--- source/tcdm_fifo.sv
/*
  Decouples a TCDM requester from a TCDM target with two queues.
  The target must answer each granted read exactly one cycle later.
  Responses leave only while ready_i is high. flags_o.empty ignores the
  holding register.
*/
`timescale 1ns/1ps
`default_nettype none

module tcdm_fifo #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  output fifo_pkg::fifo_flags_t flags_o,
  input  logic                  ready_i,
  // Slave side
  input  logic                  req_i,
  output logic                  gnt_o,
  input  tcdm_pkg::tcdm_addr_t  addr_i,
  input  tcdm_pkg::tcdm_data_t  wdata_i,
  input  tcdm_pkg::tcdm_be_t    be_i,
  input  logic                  wen_i,
  output tcdm_pkg::tcdm_data_t  r_data_o,
  output logic                  r_valid_o,
  // Master side
  output logic                  mreq_o,
  input  logic                  mgnt_i,
  output tcdm_pkg::tcdm_addr_t  maddr_o,
  output tcdm_pkg::tcdm_data_t  mwdata_o,
  output tcdm_pkg::tcdm_be_t    mbe_o,
  output logic                  mwen_o,
  input  tcdm_pkg::tcdm_data_t  mr_data_i,
  input  logic                  mr_valid_i
);

  import tcdm_pkg::*;
  import fifo_pkg::*;

  fifo_flags_t flags_out;
  fifo_flags_t flags_in;
  tcdm_req_t   out_push_data;
  tcdm_req_t   out_pop_data;
  logic        out_pop_valid;
  logic        out_pop_ready;
  logic        in_push_valid;
  logic        in_push_ready;                       // Incoming not-full
  tcdm_data_t  in_push_data;
  logic        in_pop_valid;
  logic        hold_valid_q;
  tcdm_data_t  hold_data_q;                         // Parked response

  // ####################
  // Outgoing requests
  assign out_push_data = '{addr: addr_i, data: wdata_i, be: be_i, wen: wen_i};

  stream_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH ),
    .payload_t  ( tcdm_req_t )
  ) i_fifo_outgoing (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( req_i         ),
    .push_data_i  ( out_push_data ),
    .push_ready_o ( gnt_o         ),
    .pop_valid_o  ( out_pop_valid ),
    .pop_data_o   ( out_pop_data  ),
    .pop_ready_i  ( out_pop_ready ),
    .flags_o      ( flags_out     )
  );

  // Issue only with room for the answer
  assign mreq_o        = out_pop_valid & in_push_ready;
  assign out_pop_ready = mgnt_i & in_push_ready;    // Bank grants without req
  assign maddr_o       = out_pop_data.addr;
  assign mwdata_o      = out_pop_data.data;
  assign mbe_o         = out_pop_data.be;
  assign mwen_o        = out_pop_data.wen;

  // ####################
  // Incoming responses
  assign in_push_valid = mr_valid_i | hold_valid_q;
  assign in_push_data  = mr_valid_i ? mr_data_i : hold_data_q; // Live first

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (mr_valid_i && !in_push_ready) begin
      hold_valid_q <= 1'b1;                         // Queue full, park it
    end else if (!mr_valid_i && in_push_ready) begin
      hold_valid_q <= 1'b0;                         // Parked one pushed
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (mr_valid_i && !in_push_ready) hold_data_q <= mr_data_i;
  end

  stream_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH  ),
    .payload_t  ( tcdm_data_t )
  ) i_fifo_incoming (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( in_push_valid ),
    .push_data_i  ( in_push_data  ),
    .push_ready_o ( in_push_ready ),
    .pop_valid_o  ( in_pop_valid  ),
    .pop_data_o   ( r_data_o      ),
    .pop_ready_i  ( ready_i       ),
    .flags_o      ( flags_in      )
  );

  assign r_valid_o     = in_pop_valid & ready_i;
  assign flags_o.empty = flags_out.empty & flags_in.empty;
  assign flags_o.full  = flags_out.full;

  // One parked response at most, relies on one-cycle target latency
  a_hold_no_overrun: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mr_valid_i |-> !(hold_valid_q && !in_push_ready))
    else $error("response arrived with holding register and queue both full");

endmodule

`default_nettype wire

//--- source/tcdm_bank.sv
/*
  Single-bank word memory. Only address bits above bit 1 are used,
  modulo MEM_WORDS, which must be a power of two. gnt_o follows stall_i
  alone. Read data comes one cycle after the grant.
*/
`timescale 1ns/1ps
`default_nettype none

module tcdm_bank #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 stall_i,
  input  logic                 req_i,
  output logic                 gnt_o,
  input  tcdm_pkg::tcdm_addr_t addr_i,
  input  tcdm_pkg::tcdm_data_t wdata_i,
  input  tcdm_pkg::tcdm_be_t   be_i,
  input  logic                 wen_i,
  output tcdm_pkg::tcdm_data_t r_data_o,
  output logic                 r_valid_o
);

  import tcdm_pkg::*;

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  tcdm_data_t       mem_q [MEM_WORDS];
  logic [IDX_W-1:0] idx;                            // Word index
  logic             req_en;
  tcdm_data_t       r_data_q;
  logic             r_valid_q;

  assign gnt_o  = ~stall_i;
  assign req_en = req_i & gnt_o;
  assign idx    = addr_i[IDX_W+1:2];                // Drop byte offset

  // ####################
  // Array with byte writes
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni) begin
      for (int unsigned w = 0; w < MEM_WORDS; w++) mem_q[w] <= '0;
    end else if (req_en && !wen_i) begin
      for (int unsigned b = 0; b < TCDM_BE_W; b++) begin
        if (be_i[b]) mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // ####################
  // Read response
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni) r_valid_q <= 1'b0;
    else         r_valid_q <= req_en & wen_i;       // One-cycle pulse
  end

  always_ff @(posedge clk_i)
  begin
    if (req_en && wen_i) r_data_q <= mem_q[idx];
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;

endmodule

`default_nettype wire

//--- source/tcdm_decoupled_top.sv
/*
  Decoupling FIFO in front of a single memory bank.
  Memory contents survive clear_i, queued traffic does not.
*/
`timescale 1ns/1ps
`default_nettype none

module tcdm_decoupled_top #(
  parameter int unsigned FIFO_DEPTH = 8,
  parameter int unsigned MEM_WORDS  = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 stall_i,
  input  logic                 ready_i,
  input  logic                 req_i,
  output logic                 gnt_o,
  input  tcdm_pkg::tcdm_addr_t addr_i,
  input  tcdm_pkg::tcdm_data_t wdata_i,
  input  tcdm_pkg::tcdm_be_t   be_i,
  input  logic                 wen_i,
  output tcdm_pkg::tcdm_data_t r_data_o,
  output logic                 r_valid_o,
  output logic                 empty_o,
  output logic                 full_o
);

  import tcdm_pkg::*;
  import fifo_pkg::*;

  fifo_flags_t flags;
  logic        mreq;
  logic        mgnt;
  tcdm_addr_t  maddr;
  tcdm_data_t  mwdata;
  tcdm_be_t    mbe;
  logic        mwen;
  tcdm_data_t  mr_data;
  logic        mr_valid;

  tcdm_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_tcdm_fifo (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .clear_i    ( clear_i   ),
    .flags_o    ( flags     ),
    .ready_i    ( ready_i   ),
    .req_i      ( req_i     ),
    .gnt_o      ( gnt_o     ),
    .addr_i     ( addr_i    ),
    .wdata_i    ( wdata_i   ),
    .be_i       ( be_i      ),
    .wen_i      ( wen_i     ),
    .r_data_o   ( r_data_o  ),
    .r_valid_o  ( r_valid_o ),
    .mreq_o     ( mreq      ),
    .mgnt_i     ( mgnt      ),
    .maddr_o    ( maddr     ),
    .mwdata_o   ( mwdata    ),
    .mbe_o      ( mbe       ),
    .mwen_o     ( mwen      ),
    .mr_data_i  ( mr_data   ),
    .mr_valid_i ( mr_valid  )
  );

  tcdm_bank #(
    .MEM_WORDS ( MEM_WORDS )
  ) i_tcdm_bank (
    .clk_i     ( clk_i    ),
    .rst_ni    ( rst_ni   ),
    .stall_i   ( stall_i  ),
    .req_i     ( mreq     ),
    .gnt_o     ( mgnt     ),
    .addr_i    ( maddr    ),
    .wdata_i   ( mwdata   ),
    .be_i      ( mbe      ),
    .wen_i     ( mwen     ),
    .r_data_o  ( mr_data  ),
    .r_valid_o ( mr_valid )
  );

  assign empty_o = flags.empty;
  assign full_o  = flags.full;

endmodule

`default_nettype wire

//--- test/tb_tcdm_decoupled_top.sv
/*
  Random self-checking testbench for the decoupled TCDM path.
  Inputs change 2 ns after the rising edge and outputs are sampled at the
  falling edge. The models assume the bank serves requests in order.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_decoupled_top;

  import tcdm_pkg::*;
  import fifo_pkg::*;

  localparam int unsigned FIFO_DEPTH = 8;
  localparam int unsigned MEM_WORDS  = 256;
  localparam int          CLK_PERIOD = 40;
  localparam tcdm_addr_t  ADDR_BASE  = 32'h0000_0400;   // Wraps onto word 0
  localparam int unsigned WIN_WORDS  = 16;              // Small window for frequent hits
  localparam int          PH_MIX1    = 400;
  localparam int          PH_STALL   = 60;
  localparam int          PH_HOLD    = 80;
  localparam int          PH_CLEAR   = 30;
  localparam int          PH_MIX2    = 300;
  localparam int          DRAIN_MAX  = 100;             // Cycles per drain
  localparam int          TXN_COUNT  = PH_MIX1 + PH_STALL + PH_HOLD + PH_CLEAR
                                       + PH_MIX2 + 2 * DRAIN_MAX + 30;
  localparam int          CYC_BOUND  = 4;               // Worst case per step
  localparam fifo_flags_t FLAGS_IDLE = '{empty: 1'b1, full: 1'b0};

  logic       clk_i;
  logic       rst_ni;
  logic       clear_i;
  logic       stall_i;
  logic       ready_i;
  logic       req_i;
  logic       gnt_o;
  tcdm_addr_t addr_i;
  tcdm_data_t wdata_i;
  tcdm_be_t   be_i;
  logic       wen_i;
  tcdm_data_t r_data_o;
  logic       r_valid_o;
  logic       empty_o;
  logic       full_o;

  integer     seed = 32'h1f0c1ced;
  tcdm_data_t mem_model [MEM_WORDS];                    // Reference memory
  tcdm_data_t exp_q [$];                                // Expected read data
  int         data_errs     = 0;
  int         flag_errs     = 0;
  int         bit_errs      = 0;
  int         proto_errs    = 0;
  int         reads_count   = 0;
  int         resp_count    = 0;
  int         reads_dropped = 0;                        // Lost to clear_i
  bit         granted_last  = 1'b0;
  bit         seen_full     = 1'b0;

  tcdm_decoupled_top #(
    .FIFO_DEPTH ( FIFO_DEPTH ),
    .MEM_WORDS  ( MEM_WORDS  )
  ) i_tcdm_decoupled_top (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .clear_i   ( clear_i   ),
    .stall_i   ( stall_i   ),
    .ready_i   ( ready_i   ),
    .req_i     ( req_i     ),
    .gnt_o     ( gnt_o     ),
    .addr_i    ( addr_i    ),
    .wdata_i   ( wdata_i   ),
    .be_i      ( be_i      ),
    .wen_i     ( wen_i     ),
    .r_data_o  ( r_data_o  ),
    .r_valid_o ( r_valid_o ),
    .empty_o   ( empty_o   ),
    .full_o    ( full_o    )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ####################
  // Helpers
  function automatic bit chance(int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic int unsigned word_index(tcdm_addr_t a);
    return (a >> 2) % MEM_WORDS;                        // Word address modulo depth
  endfunction

  function automatic fifo_flags_t current_flags();
    fifo_flags_t f;
    f.empty = empty_o;
    f.full  = full_o;
    return f;
  endfunction

  task automatic verify_data(string name, tcdm_data_t got, tcdm_data_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
      data_errs++;
    end
  endtask

  task automatic compare_flags(string name, fifo_flags_t got, fifo_flags_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
      flag_errs++;
    end
  endtask

  task automatic expect_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
      bit_errs++;
    end
  endtask

  task automatic apply_write(tcdm_addr_t a, tcdm_data_t d, tcdm_be_t be);
    int unsigned i;
    i = word_index(a);
    for (int b = 0; b < TCDM_BE_W; b++) begin
      if (be[b]) mem_model[i][8*b +: 8] = d[8*b +: 8];  // Byte merge
    end
  endtask

  // One random stimulus step that holds fields while a request waits
  task automatic drive_cycle(int req_pct, int wr_pct, int stall_pct, int ready_pct);
    int unsigned word;
    @(posedge clk_i);
    #2;
    stall_i = chance(stall_pct);
    ready_i = chance(ready_pct);
    if (!(req_i && !granted_last)) begin
      word    = $unsigned($random(seed)) % WIN_WORDS;
      req_i   = chance(req_pct);
      wen_i   = !chance(wr_pct);                        // Low means write
      be_i    = tcdm_be_t'($random(seed));
      wdata_i = tcdm_data_t'($random(seed));
      addr_i  = ADDR_BASE + tcdm_addr_t'(word << 2);
    end
  endtask

  task automatic drain_all();
    int cycles;
    @(posedge clk_i);
    #2;
    req_i   = 1'b0;
    stall_i = 1'b0;
    ready_i = 1'b1;
    cycles  = 0;
    while ((exp_q.size() != 0 || !empty_o) && cycles < DRAIN_MAX) begin
      @(negedge clk_i);
      #1;                                               // After the monitor
      cycles++;
    end
    if (exp_q.size() != 0 || !empty_o) begin
      $display("Drain timed out with %0d responses still missing", exp_q.size());
      proto_errs++;
    end
    repeat (2) @(negedge clk_i);
    compare_flags("flags", current_flags(), FLAGS_IDLE);
    expect_bit("gnt_o", gnt_o, 1'b1);
  endtask

  // ####################
  // Monitor and models
  always @(negedge clk_i)
  begin
    if (rst_ni && !clear_i) begin
      if (r_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("Response delivered with no read outstanding at %0t ns", $time);
          proto_errs++;
        end else begin
          verify_data("r_data_o", r_data_o, exp_q.pop_front());
          resp_count++;
        end
      end
      if (!ready_i) expect_bit("r_valid_o", r_valid_o, 1'b0);  // Held back
      if (req_i && gnt_o) begin
        if (!wen_i) begin
          apply_write(addr_i, wdata_i, be_i);
        end else begin
          exp_q.push_back(mem_model[word_index(addr_i)]);
          reads_count++;
        end
      end
      if (full_o && !gnt_o) seen_full = 1'b1;
      granted_last = req_i && gnt_o;                    // Transfers at next edge
    end
  end

  // ####################
  // Sequence
  initial
  begin
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    clear_i = 1'b0;
    stall_i = 1'b0;
    ready_i = 1'b0;
    req_i   = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    wen_i   = 1'b1;
    for (int w = 0; w < MEM_WORDS; w++) mem_model[w] = '0;  // Bank zeroes at reset
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare_flags("flags", current_flags(), FLAGS_IDLE);
    expect_bit("gnt_o", gnt_o, 1'b1);
    expect_bit("r_valid_o", r_valid_o, 1'b0);

    repeat (PH_MIX1) drive_cycle(60, 50, 20, 80);       // Mixed traffic
    seen_full = 1'b0;
    repeat (PH_STALL) drive_cycle(80, 50, 95, 80);      // Long stall bursts
    if (!seen_full) begin
      $display("Outgoing queue never filled while the bank stalled");
      proto_errs++;
    end
    repeat (PH_HOLD) drive_cycle(70, 30, 10, 0);        // Responses held back
    drain_all();

    // Reads pile up and the clear drops them
    repeat (PH_CLEAR) drive_cycle(70, 0, 0, 0);
    @(posedge clk_i);
    #2;
    req_i   = 1'b0;
    stall_i = 1'b1;
    ready_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    clear_i = 1'b1;
    reads_dropped += exp_q.size();
    exp_q.delete();
    @(posedge clk_i);
    #2;
    clear_i = 1'b0;
    ready_i = 1'b1;                                     // Nothing may come out
    @(negedge clk_i);
    compare_flags("flags", current_flags(), FLAGS_IDLE);
    expect_bit("gnt_o", gnt_o, 1'b1);
    expect_bit("r_valid_o", r_valid_o, 1'b0);

    repeat (PH_MIX2) drive_cycle(60, 50, 20, 80);       // Memory kept over clear
    drain_all();

    if (resp_count + reads_dropped != reads_count) begin
      $display("Response count %0d plus %0d dropped does not match %0d reads",
               resp_count, reads_dropped, reads_count);
      proto_errs++;
    end
    $display("Errors: data %0d, flags %0d, bits %0d, protocol %0d (%0d reads, %0d responses)",
             data_errs, flag_errs, bit_errs, proto_errs, reads_count, resp_count);
    if (data_errs + flag_errs + bit_errs + proto_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Bound on the whole run
  initial
  begin
    #(TXN_COUNT * CYC_BOUND * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
source/tcdm_pkg.sv
source/fifo_pkg.sv
source/stream_fifo.sv
source/tcdm_fifo.sv
source/tcdm_bank.sv
source/tcdm_decoupled_top.sv
test/tb_tcdm_decoupled_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the TCDM decoupling testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_tcdm_decoupled_top
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module "$TOP" \
  -Mdir "$OBJ" \
  -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
